// ==== rtl/des_pkg.sv ====
`default_nettype none

package des_pkg;

   typedef logic [63:0] des_block_t;
   typedef logic [31:0] des_half_t;
   typedef logic [1:0][27:0] des_key56_t;  // [1] is C, [0] is D.
   typedef logic [47:0] des_subkey_t;
   typedef logic [3:0] des_round_t;

   // byte offsets of the register map.
   localparam logic [4:0] reg_key_hi    = 5'h00;
   localparam logic [4:0] reg_key_lo    = 5'h04;
   localparam logic [4:0] reg_data_hi   = 5'h08;
   localparam logic [4:0] reg_data_lo   = 5'h0C;
   localparam logic [4:0] reg_ctrl      = 5'h10;
   localparam logic [4:0] reg_status    = 5'h14;
   localparam logic [4:0] reg_result_hi = 5'h18;
   localparam logic [4:0] reg_result_lo = 5'h1C;

   // source bit numbers, 1 is the msb.
   localparam int unsigned ip_table [64] = '{
      58, 50, 42, 34, 26, 18, 10, 2, 60, 52, 44, 36, 28, 20, 12, 4,
      62, 54, 46, 38, 30, 22, 14, 6, 64, 56, 48, 40, 32, 24, 16, 8,
      57, 49, 41, 33, 25, 17,  9, 1, 59, 51, 43, 35, 27, 19, 11, 3,
      61, 53, 45, 37, 29, 21, 13, 5, 63, 55, 47, 39, 31, 23, 15, 7};

   localparam int unsigned fp_table [64] = '{
      40, 8, 48, 16, 56, 24, 64, 32, 39, 7, 47, 15, 55, 23, 63, 31,
      38, 6, 46, 14, 54, 22, 62, 30, 37, 5, 45, 13, 53, 21, 61, 29,
      36, 4, 44, 12, 52, 20, 60, 28, 35, 3, 43, 11, 51, 19, 59, 27,
      34, 2, 42, 10, 50, 18, 58, 26, 33, 1, 41,  9, 49, 17, 57, 25};

   localparam int unsigned pc1_table [56] = '{
      57, 49, 41, 33, 25, 17,  9,  1, 58, 50, 42, 34, 26, 18,
      10,  2, 59, 51, 43, 35, 27, 19, 11,  3, 60, 52, 44, 36,
      63, 55, 47, 39, 31, 23, 15,  7, 62, 54, 46, 38, 30, 22,
      14,  6, 61, 53, 45, 37, 29, 21, 13,  5, 28, 20, 12,  4};

   localparam int unsigned pc2_table [48] = '{
      14, 17, 11, 24,  1,  5,  3, 28, 15,  6, 21, 10,
      23, 19, 12,  4, 26,  8, 16,  7, 27, 20, 13,  2,
      41, 52, 31, 37, 47, 55, 30, 40, 51, 45, 33, 48,
      44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32};

   localparam int unsigned e_table [48] = '{
      32,  1,  2,  3,  4,  5,  4,  5,  6,  7,  8,  9,
       8,  9, 10, 11, 12, 13, 12, 13, 14, 15, 16, 17,
      16, 17, 18, 19, 20, 21, 20, 21, 22, 23, 24, 25,
      24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32,  1};

   localparam int unsigned p_table [32] = '{
      16,  7, 20, 21, 29, 12, 28, 17,  1, 15, 23, 26,  5, 18, 31, 10,
       2,  8, 24, 14, 32, 27,  3,  9, 19, 13, 30,  6, 22, 11,  4, 25};

   // entry row*16+col, leftmost nibble is entry 0.
   localparam logic [255:0] sbox_table [8] = '{
      256'hE4D12FB83A6C5907_0F74E2D1A6CB9538_41E8D62BFC973A50_FC8249175B3EA06D,
      256'hF18E6B34972DC05A_3D47F28EC01A69B5_0E7BA4D158C6932F_D8A13F42B67C05E9,
      256'hA09E63F51DC7B428_D709346A285ECBF1_D6498F30B12C5AE7_1AD069874FE3B52C,
      256'h7DE3069A1285BC4F_D8B56F03472C1AE9_A690CB7DF13E5284_3F06A1D8945BC72E,
      256'h2C417AB6853FD0E9_EB2C47D150FA3986_421BAD78F9C5630E_B8C71E2D6F09A453,
      256'hC1AF92680D34E75B_AF427C9561DE0B38_9EF528C3704A1DB6_432C95FABE17608D,
      256'h4B2EF08D3C975A61_D0B7491AE35C2F86_14BDC37EAF680592_6BD814A7950FE23C,
      256'hD2846FB1A93E50C7_1FD8A374C56B0E92_7B419CE206ADF358_21E74A8DFC90356B};

   function automatic des_block_t permute_64(input des_block_t din,
                                             input int unsigned tbl [64]);
      des_block_t dout;
      for (int j = 0; j < 64; j++)
         dout[63 - j] = din[64 - tbl[j]];
      return dout;
   endfunction

   // 64 bit key in, parity bits fall out.
   function automatic des_key56_t permute_56(input des_block_t din,
                                             input int unsigned tbl [56]);
      logic [55:0] dout;
      for (int j = 0; j < 56; j++)
         dout[55 - j] = din[64 - tbl[j]];
      return dout;
   endfunction

   // din right aligned, in_width bits wide.
   function automatic des_subkey_t permute_48(input logic [63:0] din,
                                              input int unsigned in_width,
                                              input int unsigned tbl [48]);
      des_subkey_t dout;
      for (int j = 0; j < 48; j++)
         dout[47 - j] = din[in_width - tbl[j]];
      return dout;
   endfunction

endpackage

`default_nettype wire

// ==== rtl/des_core_if.sv ====
`default_nettype none

interface des_core_if;
   des_pkg::des_block_t key;
   des_pkg::des_block_t block;
   logic decrypt;
   logic start;  // single cycle pulse.
   logic busy;
   logic done;
   des_pkg::des_block_t result;

   modport regs (
      output key, block, decrypt, start,
      input  busy, done, result
   );

   modport engine (
      input  key, block, decrypt, start,
      output busy, done, result
   );
endinterface

`default_nettype wire

// ==== rtl/des_key_round.sv ====
`default_nettype none

module des_key_round (
   input  wire des_pkg::des_key56_t previous_key,
   input  wire des_pkg::des_round_t round,
   input  wire logic                decrypt,
   output des_pkg::des_key56_t      next_key,
   output des_pkg::des_subkey_t     subkey
);

   logic [1:0] amount;

   // shift schedule. decryption skips round 0.
   always_comb
   begin
      case (round)
         4'd0:
            amount = decrypt ? 2'd0 : 2'd1;
         4'd1, 4'd8, 4'd15:
            amount = 2'd1;
         default:
            amount = 2'd2;
      endcase
   end

   // rotate C and D the same way.
   for (genvar h = 0; h < 2; h++)
   begin : g_half
      logic [55:0] doubled;

      assign doubled = {previous_key[h], previous_key[h]};
      assign next_key[h] = decrypt ? doubled[27 + amount -: 28]  // right.
                                   : doubled[55 - amount -: 28]; // left.
   end

   assign subkey = des_pkg::permute_48({8'b0, next_key}, 56, des_pkg::pc2_table);

   // first decrypt round must use K16 unchanged.
   always_comb
   begin
      if (decrypt && round == 4'd0)
         assert (next_key == previous_key)
         else $error("key rotated in decrypt round 0");
   end

endmodule

`default_nettype wire

// ==== rtl/des_feistel.sv ====
`default_nettype none

module des_feistel (
   input  wire des_pkg::des_half_t   right,
   input  wire des_pkg::des_subkey_t subkey,
   output des_pkg::des_half_t        f_out
);

   logic [47:0] expanded;
   logic [47:0] mixed;
   logic [31:0] s_out;

   assign expanded = des_pkg::permute_48({32'b0, right}, 32, des_pkg::e_table);
   assign mixed = expanded ^ subkey;

   // eight 6 to 4 lookups, S1 on the top bits.
   for (genvar i = 0; i < 8; i++)
   begin : g_sbox
      logic [5:0] chunk;
      logic [5:0] idx;

      assign chunk = mixed[47 - 6*i -: 6];
      assign idx = {chunk[5], chunk[0], chunk[4:1]};  // outer bits pick the row.
      assign s_out[31 - 4*i -: 4] = des_pkg::sbox_table[i][255 - 4*idx -: 4];
   end

   // P permutation.
   always_comb
   begin
      for (int j = 0; j < 32; j++)
         f_out[31 - j] = s_out[32 - des_pkg::p_table[j]];
   end

endmodule

`default_nettype wire

// ==== rtl/des_round_engine.sv ====
`default_nettype none

module des_round_engine (
   input wire logic   clk,
   input wire logic   arst_n,
   des_core_if.engine core
);

   logic                 busy;
   logic                 done;
   logic                 loading;
   logic                 accept;
   des_pkg::des_round_t  round;
   des_pkg::des_block_t  result;
   des_pkg::des_block_t  block_lat;
   des_pkg::des_block_t  key_lat;
   logic                 decrypt_lat;
   des_pkg::des_half_t   l_reg;
   des_pkg::des_half_t   r_reg;
   des_pkg::des_key56_t  key_reg;
   des_pkg::des_key56_t  next_key;
   des_pkg::des_subkey_t subkey;
   des_pkg::des_half_t   f_out;
   des_pkg::des_block_t  ip_block;

   assign accept = core.start && !busy;  // start while busy is dropped.
   assign ip_block = des_pkg::permute_64(block_lat, des_pkg::ip_table);

   assign core.busy = busy;
   assign core.done = done;
   assign core.result = result;

   des_key_round u_key_round (
      .previous_key (key_reg),
      .round        (round),
      .decrypt      (decrypt_lat),
      .next_key     (next_key),
      .subkey       (subkey)
   );

   des_feistel u_feistel (
      .right  (r_reg),
      .subkey (subkey),
      .f_out  (f_out)
   );

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         busy <= 1'b0;
         done <= 1'b0;
         loading <= 1'b0;
         round <= '0;
         result <= '0;
      end
      else if (accept)
      begin
         busy <= 1'b1;
         loading <= 1'b1;
         done <= 1'b0;
      end
      else if (loading)
      begin
         loading <= 1'b0;
         round <= '0;
      end
      else if (busy)
      begin
         round <= round + 1'b1;
         if (round == 4'd15)
         begin
            busy <= 1'b0;
            done <= 1'b1;
            // last round, halves swapped, then FP.
            result <= des_pkg::permute_64({l_reg ^ f_out, r_reg}, des_pkg::fp_table);
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         block_lat <= core.block;
         key_lat <= core.key;
         decrypt_lat <= core.decrypt;
      end
      if (loading)
      begin
         l_reg <= ip_block[63:32];
         r_reg <= ip_block[31:0];
         key_reg <= des_pkg::permute_56(key_lat, des_pkg::pc1_table);
      end
      else if (busy)
      begin
         l_reg <= r_reg;
         r_reg <= l_reg ^ f_out;
         key_reg <= next_key;
      end
   end

   a_busy_done: assert property (@(posedge clk) disable iff (!arst_n) !(busy && done));

   a_round_idle: assert property (@(posedge clk) disable iff (!arst_n)
      !busy |=> $stable(round));

endmodule

`default_nettype wire

// ==== rtl/des_apb_regs.sv ====
`default_nettype none

module des_apb_regs #(
   parameter int apb_addr_width = 5
) (
   input  wire logic                      clk,
   input  wire logic                      arst_n,
   input  wire logic                      psel,
   input  wire logic                      penable,
   input  wire logic                      pwrite,
   input  wire logic [apb_addr_width-1:0] paddr,
   input  wire logic [31:0]               pwdata,
   output logic [31:0]                    prdata,
   output logic                           pready,
   output logic                           pslverr,
   des_core_if.regs                       core
);

   logic [31:0] key_hi;
   logic [31:0] key_lo;
   logic [31:0] data_hi;
   logic [31:0] data_lo;
   logic        decrypt;
   logic        start;
   logic        access;
   logic        addr_ok;
   logic [4:0]  offset;

   assign offset = paddr[4:0];
   // upper bits zero and word aligned.
   assign addr_ok = ((paddr >> 5) == '0) && (offset[1:0] == 2'b00);
   assign access = psel && penable;

   assign pready = 1'b1;
   assign pslverr = access && !addr_ok;

   assign core.key = {key_hi, key_lo};
   assign core.block = {data_hi, data_lo};
   assign core.decrypt = decrypt;
   assign core.start = start;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         key_hi <= '0;
         key_lo <= '0;
         data_hi <= '0;
         data_lo <= '0;
         decrypt <= 1'b0;
         start <= 1'b0;
      end
      else
      begin
         start <= 1'b0;
         if (access && pwrite && addr_ok)
         begin
            case (offset)
               des_pkg::reg_key_hi:  key_hi <= pwdata;
               des_pkg::reg_key_lo:  key_lo <= pwdata;
               des_pkg::reg_data_hi: data_hi <= pwdata;
               des_pkg::reg_data_lo: data_lo <= pwdata;
               des_pkg::reg_ctrl:
               begin
                  decrypt <= pwdata[1];
                  start <= pwdata[0];
               end
               default: ;  // status and result are read only.
            endcase
         end
      end
   end

   always_comb
   begin
      prdata = '0;
      if (access && !pwrite && addr_ok)
      begin
         case (offset)
            des_pkg::reg_key_hi:    prdata = key_hi;
            des_pkg::reg_key_lo:    prdata = key_lo;
            des_pkg::reg_data_hi:   prdata = data_hi;
            des_pkg::reg_data_lo:   prdata = data_lo;
            des_pkg::reg_ctrl:      prdata = {30'b0, decrypt, 1'b0};  // start reads 0.
            des_pkg::reg_status:    prdata = {30'b0, core.done, core.busy};
            des_pkg::reg_result_hi: prdata = core.result[63:32];
            des_pkg::reg_result_lo: prdata = core.result[31:0];
            default:                prdata = '0;
         endcase
      end
   end

   a_err_access: assert property (@(posedge clk) disable iff (!arst_n)
      pslverr |-> (psel && penable));

endmodule

`default_nettype wire

// ==== rtl/des_apb_top.sv ====
`default_nettype none

module des_apb_top #(
   parameter int apb_addr_width = 5
) (
   input  wire logic                      clk,
   input  wire logic                      arst_n,
   input  wire logic                      psel,
   input  wire logic                      penable,
   input  wire logic                      pwrite,
   input  wire logic [apb_addr_width-1:0] paddr,
   input  wire logic [31:0]               pwdata,
   output logic [31:0]                    prdata,
   output logic                           pready,
   output logic                           pslverr
);

   des_core_if core ();

   des_apb_regs #(
      .apb_addr_width (apb_addr_width)
   ) u_regs (
      .clk     (clk),
      .arst_n  (arst_n),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .core    (core.regs)
   );

   des_round_engine u_engine (
      .clk    (clk),
      .arst_n (arst_n),
      .core   (core.engine)
   );

endmodule

`default_nettype wire

// ==== bench/des_checker.sv ====
`default_nettype none

module des_checker (
   input wire logic        clk,
   input wire logic        psel,
   input wire logic        penable,
   input wire logic        pwrite,
   input wire logic [31:0] prdata,
   input wire logic        pready,
   input wire logic        pslverr
);
   timeunit 1ns;
   timeprecision 100ps;

   typedef struct packed {
      logic        check_data;
      logic [31:0] data;
      logic        err;
   } expect_t;

   expect_t exp_q [$];  // one entry per apb transfer.
   int errors = 0;

   task automatic push_expect(input logic check_data, input logic [31:0] data, input logic err);
      exp_q.push_back({check_data, data, err});
   endtask

   // mid access phase, well away from the edges.
   always @(negedge clk)
   begin : sample
      expect_t e;
      if (psel && penable)
      begin
         if (exp_q.size() == 0)
         begin
            errors++;
            $display("%0t: APB transfer seen with no expected response queued", $time);
         end
         else
         begin
            e = exp_q.pop_front();
            if (pready !== 1'b1)
            begin
               errors++;
               $display("FAIL %0t pready expected 1 actual %b", $time, pready);
            end
            if (pslverr !== e.err)
            begin
               errors++;
               $display("FAIL %0t pslverr expected %b actual %b", $time, e.err, pslverr);
            end
            if (!pwrite && e.check_data && prdata !== e.data)
            begin
               errors++;
               $display("FAIL %0t prdata expected %h actual %h", $time, e.data, prdata);
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== bench/tb_des_apb_top.sv ====
`default_nettype none

module tb_des_apb_top;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int clk_period = 8;
   localparam int n_vec = 6;
   localparam int n_rand = 4;
   localparam int op_budget = 80;  // cycles per entry, encrypt plus decrypt.
   localparam int timeout_ns = (n_vec + n_rand + 3) * op_budget * clk_period * 2;

   // key, plaintext, ciphertext.
   localparam logic [191:0] vec_table [n_vec] = '{
      {64'h133457799BBCDFF1, 64'h0123456789ABCDEF, 64'h85E813540F0AB405},
      {64'h0101010101010101, 64'h8000000000000000, 64'h95F8A5E5DD31D900},
      {64'h0101010101010101, 64'h4000000000000000, 64'hDD7F121CA5015619},
      {64'h0101010101010101, 64'h2000000000000000, 64'h2E8653104F3834EA},
      {64'h0101010101010101, 64'h1000000000000000, 64'h4BD388FF6CD81D4F},
      {64'h0E329232EA6D0D73, 64'h8787878787878787, 64'h0000000000000000}};

   logic        clk;
   logic        arst_n;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [7:0]  paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;
   int          bench_errors = 0;
   integer      seed = 32'h22353bb4;

   des_apb_top #(
      .apb_addr_width (8)  // wide enough to reach 0x20 and up.
   ) i_dut (
      .clk     (clk),
      .arst_n  (arst_n),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr)
   );

   des_checker u_checker (
      .clk     (clk),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr)
   );

   initial
   begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   // callers start 1 ns after a rising edge.
   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, input logic err);
      u_checker.push_expect(1'b0, 32'h0, err);
      psel = 1'b1;
      penable = 1'b0;
      pwrite = 1'b1;
      paddr = addr;
      pwdata = data;
      @(posedge clk);
      #1;
      penable = 1'b1;
      @(posedge clk);
      #1;
      psel = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_read(input logic [7:0] addr, input logic check, input logic [31:0] exp,
                           input logic err, output logic [31:0] data);
      u_checker.push_expect(check, exp, err);
      psel = 1'b1;
      penable = 1'b0;
      pwrite = 1'b0;
      paddr = addr;
      @(posedge clk);
      #1;
      penable = 1'b1;
      @(negedge clk);
      data = prdata;
      @(posedge clk);
      #1;
      psel = 1'b0;
      penable = 1'b0;
   endtask

   task automatic read_check(input logic [7:0] addr, input logic [31:0] exp);
      logic [31:0] unused;
      apb_read(addr, 1'b1, exp, 1'b0, unused);
   endtask

   task automatic load_regs(input logic [63:0] key, input logic [63:0] blk);
      apb_write(8'(des_pkg::reg_key_hi), key[63:32], 1'b0);
      apb_write(8'(des_pkg::reg_key_lo), key[31:0], 1'b0);
      apb_write(8'(des_pkg::reg_data_hi), blk[63:32], 1'b0);
      apb_write(8'(des_pkg::reg_data_lo), blk[31:0], 1'b0);
   endtask

   task automatic start_op(input logic dec);
      apb_write(8'(des_pkg::reg_ctrl), {30'b0, dec, 1'b1}, 1'b0);
   endtask

   // 20 polls of two cycles each.
   task automatic wait_done();
      logic [31:0] st;
      int polls;
      st = '0;
      polls = 0;
      while (!st[1] && polls < 20)
      begin
         apb_read(8'(des_pkg::reg_status), 1'b0, 32'h0, 1'b0, st);
         polls++;
      end
      if (!st[1])
      begin
         bench_errors++;
         $display("%0t: done bit did not rise within 40 cycles of start", $time);
      end
   endtask

   task automatic finish_op(input logic check, input logic [63:0] exp, output logic [63:0] res);
      logic [31:0] hi;
      logic [31:0] lo;
      wait_done();
      read_check(8'(des_pkg::reg_status), 32'h2);  // done, idle.
      apb_read(8'(des_pkg::reg_result_hi), check, exp[63:32], 1'b0, hi);
      apb_read(8'(des_pkg::reg_result_lo), check, exp[31:0], 1'b0, lo);
      res = {hi, lo};
   endtask

   task automatic run_op(input logic [63:0] key, input logic [63:0] blk, input logic dec,
                         input logic check, input logic [63:0] exp, output logic [63:0] res);
      load_regs(key, blk);
      start_op(dec);
      finish_op(check, exp, res);
   endtask

   initial
   begin
      #(timeout_ns);
      $display("timeout: run did not finish within %0d ns", timeout_ns);
      $display("tests failed");
      $finish;
   end

   initial
   begin
      logic [63:0] res;
      logic [63:0] key;
      logic [63:0] blk;
      logic [31:0] rd;
      int total;
      arst_n = 1'b0;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      paddr = '0;
      pwdata = '0;
      repeat (8) @(posedge clk);
      #1;
      arst_n = 1'b1;

      for (int off = 0; off < 32; off += 4)
         read_check(8'(off), 32'h0);

      // readback, then busy one cycle after start.
      load_regs(vec_table[0][191:128], vec_table[0][127:64]);
      apb_write(8'(des_pkg::reg_ctrl), 32'h2, 1'b0);
      read_check(8'(des_pkg::reg_key_hi), vec_table[0][191:160]);
      read_check(8'(des_pkg::reg_key_lo), vec_table[0][159:128]);
      read_check(8'(des_pkg::reg_data_hi), vec_table[0][127:96]);
      read_check(8'(des_pkg::reg_data_lo), vec_table[0][95:64]);
      read_check(8'(des_pkg::reg_ctrl), 32'h2);
      start_op(1'b0);
      read_check(8'(des_pkg::reg_status), 32'h1);
      finish_op(1'b1, vec_table[0][63:0], res);

      for (int i = 0; i < n_vec; i++)
      begin
         key = vec_table[i][191:128];
         run_op(key, vec_table[i][127:64], 1'b0, 1'b1, vec_table[i][63:0], res);
         run_op(key, vec_table[i][63:0], 1'b1, 1'b1, vec_table[i][127:64], res);
      end

      for (int i = 0; i < n_rand; i++)
      begin
         key = {$random(seed), $random(seed)};
         blk = {$random(seed), $random(seed)};
         run_op(key, blk, 1'b0, 1'b0, 64'h0, res);
         run_op(key, res, 1'b1, 1'b1, blk, res);
      end

      // second start lands mid operation.
      load_regs(vec_table[0][191:128], vec_table[0][127:64]);
      start_op(1'b0);
      load_regs(vec_table[1][191:128], vec_table[1][127:64]);
      start_op(1'b1);
      finish_op(1'b1, vec_table[0][63:0], res);
      read_check(8'(des_pkg::reg_ctrl), 32'h2);
      start_op(1'b0);
      finish_op(1'b1, vec_table[1][63:0], res);

      apb_write(8'h20, 32'hFFFF_FFFF, 1'b1);  // would alias key_hi.
      apb_write(8'h24, 32'hFFFF_FFFF, 1'b1);
      apb_write(8'hA8, 32'hFFFF_FFFF, 1'b1);
      apb_write(8'h01, 32'hFFFF_FFFF, 1'b1);
      apb_write(8'h13, 32'h0000_0003, 1'b1);  // misaligned start.
      apb_read(8'h20, 1'b1, 32'h0, 1'b1, rd);
      apb_read(8'h0A, 1'b1, 32'h0, 1'b1, rd);
      read_check(8'(des_pkg::reg_key_hi), vec_table[1][191:160]);
      read_check(8'(des_pkg::reg_key_lo), vec_table[1][159:128]);
      read_check(8'(des_pkg::reg_data_hi), vec_table[1][127:96]);
      read_check(8'(des_pkg::reg_data_lo), vec_table[1][95:64]);
      read_check(8'(des_pkg::reg_ctrl), 32'h0);
      read_check(8'(des_pkg::reg_status), 32'h2);

      total = u_checker.errors + bench_errors + u_checker.exp_q.size();
      $display("checker errors %0d, bench errors %0d, unmatched expectations %0d",
               u_checker.errors, bench_errors, u_checker.exp_q.size());
      if (total == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== des_apb_top.f ====
rtl/des_pkg.sv
rtl/des_core_if.sv
rtl/des_key_round.sv
rtl/des_feistel.sv
rtl/des_round_engine.sv
rtl/des_apb_regs.sv
rtl/des_apb_top.sv
bench/des_checker.sv
bench/tb_des_apb_top.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the DES APB testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f des_apb_top.f --top-module tb_des_apb_top -o sim_tb
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qx "all tests passed"; then
   exit 0
fi
exit 1
